// File: tb.f
design/uart_rx_pkg.sv
design/baud_tick_gen.sv
design/uart_rx_deserializer.sv
design/rx_fifo.sv
design/rx_read_port.sv
design/uart_rx_top.sv
sim/uart_rx_properties.sv
sim/tb_uart_rx.sv

// File: Bender.yml
package:
  name: uart_rx

sources:
  - design/uart_rx_pkg.sv
  - design/baud_tick_gen.sv
  - design/uart_rx_deserializer.sv
  - design/rx_fifo.sv
  - design/rx_read_port.sv
  - design/uart_rx_top.sv
  - target: simulation
    files:
      - sim/uart_rx_properties.sv
      - sim/tb_uart_rx.sv

// File: sim/tb_uart_rx.sv
`timescale 1ns/100ps

module tb_uart_rx;

	localparam int CLOCK_RATE   = 25_000_000;
	localparam int BAUD_RATE    = 390_625;
	localparam int FIFO_DEPTH   = 4;
	localparam int BIT_CYCLES   = CLOCK_RATE / BAUD_RATE;
	localparam int FRAME_BITS   = uart_rx_pkg::NUM_DATA_BITS + 2;
	localparam int FRAME_CYCLES = FRAME_BITS * BIT_CYCLES;
	localparam int READ_BOUND   = 16;

	typedef enum int {SIG_READY, SIG_WAITING, SIG_IDLE} watch_t;

	logic                   baud_rx_clock = 1'b0;
	logic                   i_rst_n;
	logic                   i_rx;
	logic                   i_request;
	uart_rx_pkg::rx_word_t  o_rdata;
	logic                   o_ready;
	logic                   o_waiting;
	logic                   o_frame_error;
	logic                   o_overflow;
	uart_rx_pkg::rx_state_t o_rx_state;

	int          mismatch_count  = 0;
	int          timeout_count   = 0;
	int          error_pulses    = 0;
	int          overflow_pulses = 0;
	logic [31:0] lcg_state       = 32'heb1b;

	uart_rx_top #(
		.CLOCK_RATE(CLOCK_RATE),
		.BAUD_RATE (BAUD_RATE),
		.FIFO_DEPTH(FIFO_DEPTH)
	) DUT (
		.baud_rx_clock(baud_rx_clock),
		.i_rst_n      (i_rst_n),
		.i_rx         (i_rx),
		.i_request    (i_request),
		.o_rdata      (o_rdata),
		.o_ready      (o_ready),
		.o_waiting    (o_waiting),
		.o_frame_error(o_frame_error),
		.o_overflow   (o_overflow),
		.o_rx_state   (o_rx_state)
	);

	always #20 baud_rx_clock = ~baud_rx_clock;

	// pulses are one cycle wide, so each one spans exactly one falling edge
	always @(negedge baud_rx_clock) begin
		if (o_frame_error)
			error_pulses++;
		if (o_overflow)
			overflow_pulses++;
	end

	function automatic uart_rx_pkg::rx_byte_t random_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	function automatic uart_rx_pkg::rx_word_t expected_word(input uart_rx_pkg::rx_byte_t data);
		return {data, data, data, data};
	endfunction

	function automatic logic watched(input watch_t sig);
		case (sig)
			SIG_READY:   return o_ready;
			SIG_WAITING: return o_waiting;
			default:     return o_rx_state == uart_rx_pkg::IDLE;
		endcase
	endfunction

	task automatic check_word(input string test, input uart_rx_pkg::rx_word_t expected,
		input uart_rx_pkg::rx_word_t actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH %s: expected %h, actual %h", test, expected, actual);
		end
	endtask

	task automatic check_state(input string test, input uart_rx_pkg::rx_state_t expected,
		input uart_rx_pkg::rx_state_t actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH %s: expected %s, actual %s", test, expected.name(), actual.name());
		end
	endtask

	task automatic check_flag(input string test, input logic expected, input logic actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH %s: expected %b, actual %b", test, expected, actual);
		end
	endtask

	task automatic check_count(input string test, input int expected, input int actual);
		if (actual != expected) begin
			mismatch_count++;
			$display("MISMATCH %s: expected %0d pulses, actual %0d", test, expected, actual);
		end
	endtask

	task automatic wait_for(input string test, input watch_t sig, input logic level,
		input int bound);
		int cycles;
		cycles = 0;
		while (watched(sig) !== level && cycles < bound) begin
			@(negedge baud_rx_clock);
			cycles++;
		end
		if (watched(sig) !== level) begin
			timeout_count++;
			$display("ERROR %s: %s did not reach %b within %0d cycles", test, sig.name(), level,
				bound);
		end
	endtask

	// start bit, data LSB first, stop bit, then one idle bit
	task automatic send_frame(input uart_rx_pkg::rx_byte_t data, input logic stop_bit);
		logic [FRAME_BITS-1:0] bits;
		bits = {stop_bit, data, 1'b0};
		for (int i = 0; i < FRAME_BITS; i++) begin
			i_rx = bits[i];
			repeat (BIT_CYCLES) @(negedge baud_rx_clock);
		end
		i_rx = 1'b1;
		repeat (BIT_CYCLES) @(negedge baud_rx_clock);
	endtask

	task automatic read_word(input string test, output uart_rx_pkg::rx_word_t word);
		i_request = 1'b1;
		wait_for(test, SIG_READY, 1'b1, READ_BOUND);
		word = o_rdata;
		i_request = 1'b0;
		wait_for(test, SIG_READY, 1'b0, READ_BOUND);
	endtask

	task automatic probe_waiting(input string test);
		i_request = 1'b1;
		wait_for(test, SIG_WAITING, 1'b1, 2);
		check_flag(test, 1'b1, o_waiting);
		i_request = 1'b0;
		wait_for(test, SIG_WAITING, 1'b0, READ_BOUND);
	endtask

	task automatic test_single_byte();
		uart_rx_pkg::rx_word_t word;
		check_flag("reset", 1'b0, o_ready);
		check_flag("reset", 1'b0, o_waiting);
		check_flag("reset", 1'b0, o_frame_error);
		check_flag("reset", 1'b0, o_overflow);
		check_word("reset", '0, o_rdata);
		check_state("reset", uart_rx_pkg::IDLE, o_rx_state);
		send_frame(8'ha5, 1'b1);
		check_state("single_byte", uart_rx_pkg::IDLE, o_rx_state);
		read_word("single_byte", word);
		check_word("single_byte", expected_word(8'ha5), word);
	endtask

	task automatic test_waiting();
		uart_rx_pkg::rx_byte_t data;
		data = random_byte();
		i_request = 1'b1;
		wait_for("waiting", SIG_WAITING, 1'b1, 2);
		check_flag("waiting", 1'b1, o_waiting);
		send_frame(data, 1'b1);
		wait_for("waiting", SIG_READY, 1'b1, READ_BOUND);
		check_flag("waiting", 1'b0, o_waiting);
		check_word("waiting", expected_word(data), o_rdata);
		i_request = 1'b0;
		wait_for("waiting", SIG_READY, 1'b0, READ_BOUND);
	endtask

	task automatic test_burst_order();
		uart_rx_pkg::rx_byte_t sent [$];
		uart_rx_pkg::rx_word_t word;
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			sent.push_back(random_byte());
			send_frame(sent[i], 1'b1);
		end
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			read_word("burst_order", word);
			check_word("burst_order", expected_word(sent[i]), word);
		end
		probe_waiting("burst_order");
	endtask

	task automatic test_frame_error();
		uart_rx_pkg::rx_word_t word;
		int errors_before;
		errors_before = error_pulses;
		send_frame(8'h3c, 1'b0);
		check_count("frame_error", errors_before + 1, error_pulses);
		probe_waiting("frame_error");
		// the low stop bit is still low past the start qualification, so the receiver
		// takes it as a new start and reads the idle line as an all-ones byte
		check_state("frame_error", uart_rx_pkg::DATA_BITS, o_rx_state);
		wait_for("frame_error", SIG_IDLE, 1'b1, FRAME_CYCLES);
		read_word("frame_error", word);
		check_word("frame_error", expected_word(8'hff), word);
		check_count("frame_error", errors_before + 1, error_pulses);
		probe_waiting("frame_error");
	endtask

	task automatic test_false_start();
		uart_rx_pkg::rx_byte_t data;
		uart_rx_pkg::rx_word_t word;
		int errors_before;
		errors_before = error_pulses;
		data = random_byte();
		i_rx = 1'b0;
		repeat (BIT_CYCLES / 4) @(negedge baud_rx_clock);
		i_rx = 1'b1;
		repeat (BIT_CYCLES) @(negedge baud_rx_clock);
		check_state("false_start", uart_rx_pkg::IDLE, o_rx_state);
		check_count("false_start", errors_before, error_pulses);
		probe_waiting("false_start");
		send_frame(data, 1'b1);
		read_word("false_start", word);
		check_word("false_start", expected_word(data), word);
	endtask

	task automatic test_overflow();
		uart_rx_pkg::rx_byte_t sent [$];
		uart_rx_pkg::rx_word_t word;
		int overflow_before;
		overflow_before = overflow_pulses;
		for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
			sent.push_back(random_byte());
			send_frame(sent[i], 1'b1);
		end
		check_count("overflow", overflow_before + 2, overflow_pulses);
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			read_word("overflow", word);
			check_word("overflow", expected_word(sent[i]), word);
		end
		probe_waiting("overflow");
	endtask

	initial begin
		repeat (40 * FRAME_CYCLES + 1000) @(posedge baud_rx_clock);
		$display("ERROR: watchdog expired, the tests did not finish in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		int total;
		i_rst_n = 1'b0;
		i_rx = 1'b1;
		i_request = 1'b0;
		repeat (5) @(negedge baud_rx_clock);
		i_rst_n = 1'b1;
		test_single_byte();
		test_waiting();
		test_burst_order();
		test_frame_error();
		test_false_start();
		test_overflow();
		total = mismatch_count + timeout_count + DUT.u_properties.violation_count;
		$display("summary: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatch_count, timeout_count, DUT.u_properties.violation_count);
		if (total == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: sim/uart_rx_properties.sv
`timescale 1ns/100ps

module uart_rx_properties (
	input logic                   baud_rx_clock,
	input logic                   i_rst_n,
	input logic                   i_request,
	input logic                   i_ready,
	input logic                   i_waiting,
	input logic                   i_fifo_read,
	input logic                   i_fifo_empty,
	input uart_rx_pkg::rx_state_t i_rx_state
);

	int violation_count = 0;

	a_ready_waiting_exclusive: assert property (@(posedge baud_rx_clock) disable iff (!i_rst_n)
		!(i_ready && i_waiting))
	else begin
		violation_count++;
		$error("o_ready and o_waiting are high together");
	end

	// the request is sampled in the cycle before o_ready rises
	a_ready_needs_request: assert property (@(posedge baud_rx_clock) disable iff (!i_rst_n)
		$rose(i_ready) |-> $past(i_request))
	else begin
		violation_count++;
		$error("o_ready rose without a pending request");
	end

	a_no_pop_when_empty: assert property (@(posedge baud_rx_clock) disable iff (!i_rst_n)
		i_fifo_read |-> !i_fifo_empty)
	else begin
		violation_count++;
		$error("fifo_read pulsed while the FIFO was empty");
	end

	a_idle_exits_to_start: assert property (@(posedge baud_rx_clock) disable iff (!i_rst_n)
		(i_rx_state == uart_rx_pkg::IDLE) |=>
			(i_rx_state inside {uart_rx_pkg::IDLE, uart_rx_pkg::START_BIT}))
	else begin
		violation_count++;
		$error("receiver left IDLE for a state other than START_BIT");
	end

endmodule

bind uart_rx_top uart_rx_properties u_properties (
	.baud_rx_clock(baud_rx_clock),
	.i_rst_n      (i_rst_n),
	.i_request    (i_request),
	.i_ready      (o_ready),
	.i_waiting    (o_waiting),
	.i_fifo_read  (fifo_read),
	.i_fifo_empty (fifo_empty),
	.i_rx_state   (o_rx_state)
);

// File: design/uart_rx_top.sv
`timescale 1ns/100ps

module uart_rx_top #(
	parameter int CLOCK_RATE = 50_000_000,
	parameter int BAUD_RATE  = 9600,
	parameter int FIFO_DEPTH = 32
) (
	input  logic                   baud_rx_clock,
	input  logic                   i_rst_n,
	input  logic                   i_rx,
	input  logic                   i_request,
	output uart_rx_pkg::rx_word_t  o_rdata,
	output logic                   o_ready,
	output logic                   o_waiting,
	output logic                   o_frame_error,
	output logic                   o_overflow,
	output uart_rx_pkg::rx_state_t o_rx_state
);

	logic                  tick;
	logic                  byte_valid;
	uart_rx_pkg::rx_byte_t byte_data;
	logic                  fifo_empty;
	logic                  fifo_read;
	uart_rx_pkg::rx_byte_t fifo_rdata;

	baud_tick_gen #(
		.CLOCK_RATE(CLOCK_RATE),
		.BAUD_RATE (BAUD_RATE)
	) u_tick_gen (
		.baud_rx_clock(baud_rx_clock),
		.i_rst_n      (i_rst_n),
		.o_tick       (tick)
	);

	uart_rx_deserializer u_deserializer (
		.baud_rx_clock(baud_rx_clock),
		.i_rst_n      (i_rst_n),
		.i_tick       (tick),
		.i_rx         (i_rx),
		.o_byte_valid (byte_valid),
		.o_byte_data  (byte_data),
		.o_frame_error(o_frame_error),
		.o_state      (o_rx_state)
	);

	rx_fifo #(
		.DEPTH(FIFO_DEPTH)
	) u_fifo (
		.baud_rx_clock(baud_rx_clock),
		.i_rst_n      (i_rst_n),
		.i_write      (byte_valid),
		.i_wdata      (byte_data),
		.i_read       (fifo_read),
		.o_rdata      (fifo_rdata),
		.o_empty      (fifo_empty),
		.o_overflow   (o_overflow)
	);

	rx_read_port u_read_port (
		.baud_rx_clock(baud_rx_clock),
		.i_rst_n      (i_rst_n),
		.i_request    (i_request),
		.i_fifo_empty (fifo_empty),
		.i_fifo_rdata (fifo_rdata),
		.o_fifo_read  (fifo_read),
		.o_rdata      (o_rdata),
		.o_ready      (o_ready),
		.o_waiting    (o_waiting)
	);

endmodule

// File: design/rx_read_port.sv
`timescale 1ns/100ps

module rx_read_port (
	input  logic                  baud_rx_clock,
	input  logic                  i_rst_n,
	input  logic                  i_request,
	input  logic                  i_fifo_empty,
	input  uart_rx_pkg::rx_byte_t i_fifo_rdata,
	output logic                  o_fifo_read,
	output uart_rx_pkg::rx_word_t o_rdata,
	output logic                  o_ready,
	output logic                  o_waiting
);

	typedef enum logic [1:0] {
		CHECK   = 2'b00,
		POP     = 2'b01,
		PRESENT = 2'b10,
		HOLD    = 2'b11
	} port_state_t;

	port_state_t state;

	always_ff @(posedge baud_rx_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state       <= CHECK;
			o_fifo_read <= 1'b0;
			o_rdata     <= '0;
			o_ready     <= 1'b0;
			o_waiting   <= 1'b0;
		end else begin
			o_fifo_read <= 1'b0;
			unique case (state)
				CHECK: begin
					if (!i_request) begin
						o_waiting <= 1'b0;
					end else if (!i_fifo_empty) begin
						o_waiting   <= 1'b0;
						o_fifo_read <= 1'b1;
						state       <= POP;
					end else begin
						o_waiting <= 1'b1;
					end
				end
				// the FIFO registers the popped byte during this cycle
				POP: begin
					state <= PRESENT;
				end
				PRESENT: begin
					if (i_request) begin
						o_rdata <= {4{i_fifo_rdata}};
						o_ready <= 1'b1;
						state   <= HOLD;
					end else begin
						state <= CHECK;
					end
				end
				HOLD: begin
					// one request takes one byte, so stay here until the master lets go
					if (!i_request) begin
						o_ready <= 1'b0;
						state   <= CHECK;
					end
				end
			endcase
		end
	end

endmodule

// File: design/rx_fifo.sv
`timescale 1ns/100ps

module rx_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                  baud_rx_clock,
	input  logic                  i_rst_n,
	input  logic                  i_write,
	input  uart_rx_pkg::rx_byte_t i_wdata,
	input  logic                  i_read,
	output uart_rx_pkg::rx_byte_t o_rdata,
	output logic                  o_empty,
	output logic                  o_overflow
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
		$error("rx_fifo: DEPTH must be a power of two and at least 2");
	end

	uart_rx_pkg::rx_byte_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          empty;
	logic          full;
	logic          do_write;
	logic          do_read;

	assign empty   = (count == '0);
	assign full    = (count == (AW + 1)'(DEPTH));
	assign o_empty = empty;

	// a pop in the same cycle frees the slot that a write into a full FIFO needs
	assign do_read  = i_read && !empty;
	assign do_write = i_write && (!full || do_read);

	always_ff @(posedge baud_rx_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			o_overflow <= 1'b0;
		end else begin
			o_overflow <= i_write && !do_write;
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge baud_rx_clock) begin
		if (do_write) begin
			mem[wr_ptr] <= i_wdata;
		end
	end

	always_ff @(posedge baud_rx_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_rdata <= '0;
		end else if (do_read) begin
			o_rdata <= mem[rd_ptr];
		end
	end

endmodule

// File: design/uart_rx_deserializer.sv
`timescale 1ns/100ps

module uart_rx_deserializer (
	input  logic                   baud_rx_clock,
	input  logic                   i_rst_n,
	input  logic                   i_tick,
	input  logic                   i_rx,
	output logic                   o_byte_valid,
	output uart_rx_pkg::rx_byte_t  o_byte_data,
	output logic                   o_frame_error,
	output uart_rx_pkg::rx_state_t o_state
);

	localparam int SW = $clog2(uart_rx_pkg::OVERSAMPLE);
	localparam int BW = $clog2(uart_rx_pkg::NUM_DATA_BITS);
	localparam int DW = $bits(uart_rx_pkg::rx_byte_t);

	localparam logic [SW-1:0] LAST_SAMPLE = SW'(uart_rx_pkg::OVERSAMPLE - 1);
	// the first low sample lags the edge by up to a tick and seven more ticks land near mid-bit
	localparam logic [SW-1:0] START_MID = SW'(uart_rx_pkg::OVERSAMPLE / 2 - 2);
	localparam logic [BW-1:0] LAST_BIT = BW'(uart_rx_pkg::NUM_DATA_BITS - 1);

	logic [1:0]             rx_sync;
	logic                   rx_line;
	uart_rx_pkg::rx_state_t state;
	logic [SW-1:0]          sample_cnt;
	logic [BW-1:0]          bit_cnt;
	uart_rx_pkg::rx_byte_t  shift_reg;
	logic                   data_sample;

	assign rx_line     = rx_sync[1];
	assign o_state     = state;
	assign o_byte_data = shift_reg;

	assign data_sample = i_tick && (state == uart_rx_pkg::DATA_BITS) &&
		(sample_cnt == LAST_SAMPLE);

	// the idle line is high, so the synchronizer comes out of reset high
	always_ff @(posedge baud_rx_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rx_sync <= 2'b11;
		end else begin
			rx_sync <= {rx_sync[0], i_rx};
		end
	end

	always_ff @(posedge baud_rx_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state         <= uart_rx_pkg::IDLE;
			sample_cnt    <= '0;
			bit_cnt       <= '0;
			o_byte_valid  <= 1'b0;
			o_frame_error <= 1'b0;
		end else begin
			o_byte_valid  <= 1'b0;
			o_frame_error <= 1'b0;
			if (i_tick) begin
				unique case (state)
					uart_rx_pkg::IDLE: begin
						if (!rx_line) begin
							state      <= uart_rx_pkg::START_BIT;
							sample_cnt <= '0;
						end
					end
					uart_rx_pkg::START_BIT: begin
						if (sample_cnt == START_MID) begin
							sample_cnt <= '0;
							bit_cnt    <= '0;
							// a line that is high again was only a glitch
							if (rx_line) begin
								state <= uart_rx_pkg::IDLE;
							end else begin
								state <= uart_rx_pkg::DATA_BITS;
							end
						end else begin
							sample_cnt <= sample_cnt + 1'b1;
						end
					end
					uart_rx_pkg::DATA_BITS: begin
						if (sample_cnt == LAST_SAMPLE) begin
							sample_cnt <= '0;
							if (bit_cnt == LAST_BIT) begin
								state <= uart_rx_pkg::STOP_BIT;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end else begin
							sample_cnt <= sample_cnt + 1'b1;
						end
					end
					uart_rx_pkg::STOP_BIT: begin
						if (sample_cnt == LAST_SAMPLE) begin
							state <= uart_rx_pkg::IDLE;
							if (rx_line) begin
								o_byte_valid <= 1'b1;
							end else begin
								o_frame_error <= 1'b1;
							end
						end else begin
							sample_cnt <= sample_cnt + 1'b1;
						end
					end
				endcase
			end
		end
	end

	// LSB arrives first, so bits enter at the top and move down
	always_ff @(posedge baud_rx_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			shift_reg <= '0;
		end else if (data_sample) begin
			shift_reg <= {rx_line, shift_reg[DW-1:1]};
		end
	end

endmodule

// File: design/baud_tick_gen.sv
`timescale 1ns/100ps

module baud_tick_gen #(
	parameter int CLOCK_RATE = 50_000_000,
	parameter int BAUD_RATE  = 9600
) (
	input  logic baud_rx_clock,
	input  logic i_rst_n,
	output logic o_tick
);

	localparam int TICK_RATE = BAUD_RATE * uart_rx_pkg::OVERSAMPLE;
	localparam int DIVISOR   = CLOCK_RATE / TICK_RATE;
	localparam int CW        = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;

	if (DIVISOR < 1) begin : g_divisor_low
		$error("baud_tick_gen: clock rate too low for the requested baud rate");
	end

	if (CLOCK_RATE % TICK_RATE != 0) begin : g_divisor_frac
		$error("baud_tick_gen: clock rate is not an integer multiple of 16x baud");
	end

	logic [CW-1:0] count;

	// counts down from DIVISOR-1 and pulses on the cycle after reaching zero
	always_ff @(posedge baud_rx_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			count  <= CW'(DIVISOR - 1);
			o_tick <= 1'b0;
		end else begin
			o_tick <= (count == '0);
			if (count == '0) begin
				count <= CW'(DIVISOR - 1);
			end else begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// File: design/uart_rx_pkg.sv
package uart_rx_pkg;

	// one received data byte
	typedef logic [7:0] rx_byte_t;

	// read bus word that carries the byte in every lane
	typedef logic [31:0] rx_word_t;

	typedef enum logic [1:0] {
		IDLE      = 2'b00,
		START_BIT = 2'b01,
		DATA_BITS = 2'b10,
		STOP_BIT  = 2'b11
	} rx_state_t;

	// ticks per serial bit
	localparam int OVERSAMPLE = 16;

	// data bits per 8N1 frame
	localparam int NUM_DATA_BITS = 8;

endpackage
